// ==== Makefile ====
# Verilator build and run of the NoC router testbench

TOP = tb_noc_router
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
+incdir+hdl
hdl/noc_pkg.sv
hdl/route_pkg.sv
hdl/input_fifo.sv
hdl/route_calc.sv
hdl/switch_control.sv
hdl/crossbar_switch.sv
hdl/noc_router.sv
dv/tb_noc_router.sv

// ==== dv/tb_noc_router.sv ====
`include "noc_cfg.svh"

module tb_noc_router import noc_pkg::*, route_pkg::*; ();

  localparam int N             = `NOC_PORTS;
  localparam int X_LOC         = 1;   // Router position under test
  localparam int Y_LOC         = 2;
  localparam int CLK_PERIOD    = 100;
  localparam int DRIVE_DLY     = 10;  // Inputs change just after the edge
  localparam int RANDOM_CYCLES = 400;
  localparam int DIRECTED_CYCLES = 100; // Reset, directed tests and drains
  localparam int MAX_CYCLES    = 4 * (RANDOM_CYCLES + DIRECTED_CYCLES); // 2000
  localparam int DRAIN_CYCLES  = 2 * N * `NOC_FIFO_DEPTH; // All queues full toward one output

  logic              clk;
  logic              reset_n;
  packet_t   [N-1:0] i_data;
  port_set_t         i_data_val;
  port_set_t         o_en;
  packet_t   [N-1:0] o_data;
  port_set_t         o_data_val;
  port_set_t         i_en;

  packet_t     exp_q [N*N][$];  // Model with one queue per [input][output]
  int          errors    = 0;
  int          n_checks  = 0;
  int          n_in      = 0;
  int          n_out     = 0;
  int          cycle_cnt = 0;
  logic [31:0] rng       = 32'hb1f4;

  noc_router #(.X_LOC(X_LOC), .Y_LOC(Y_LOC)) i_dut (
    .clk,
    .reset_n,
    .i_data,
    .i_data_val,
    .o_en,
    .o_data,
    .o_data_val,
    .i_en
  );

  // Helpers
  // ------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // XY rule of the mesh with X settled before Y
  function automatic int expected_port(input int dx, input int dy);
    if (dx != X_LOC) begin
      return (dx > X_LOC) ? PORT_EAST : PORT_WEST;
    end
    if (dy == Y_LOC) begin
      return PORT_CORE;
    end
    return (dy > Y_LOC) ? PORT_NORTH : PORT_SOUTH;
  endfunction

  function automatic packet_t make_pkt(input int dx, input int dy, input int src,
                                       input logic [`NOC_PAYLOAD_W-1:0] data);
    packet_t p;
    p.dest_x   = `NOC_COORD_W'(dx);
    p.dest_y   = `NOC_COORD_W'(dy);
    p.src_port = 3'(src);
    p.payload  = data;
    return p;
  endfunction

  function automatic int model_size();
    int total;
    total = 0;
    for (int q = 0; q < N*N; q++) begin
      total += exp_q[q].size();
    end
    return total;
  endfunction

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("error %s: expected %0h actual %0h", test, expected, actual);
  endtask

  task automatic log_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // All outputs open until every sent packet has come out
  task automatic drain_all();
    int waited;
    waited     = 0;
    i_data_val = '0;
    i_en       = '1;
    while (model_size() != 0 && waited < DRAIN_CYCLES) begin
      next_cycle();
      waited++;
    end
    n_checks++;
    if (model_size() != 0) begin
      log_failure($sformatf("%0d packets never came out", model_size()));
    end
    next_cycle();
  endtask

  // Clock and run limit
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Scoreboard sampled mid-cycle where all signals are settled
  // ------------------------------
  always @(negedge clk) begin
    packet_t exp_p;
    int      tag;
    if (reset_n) begin
      for (int o = 0; o < N; o++) begin      // Outputs before inputs since a new entry cannot leave yet
        if (o_data_val[o]) begin
          n_checks++;
          tag = int'(o_data[o].src_port);
          if (!i_en[o]) begin
            log_failure($sformatf("Output %0d strobed valid while its enable was low", o));
          end
          if (tag >= N) begin
            log_failure($sformatf("Output %0d carried unknown source tag %0d", o, tag));
          end else if (exp_q[tag*N + o].size() == 0) begin
            log_failure($sformatf("Output %0d delivered a packet never sent from %0d",
                                  o, tag));
          end else begin
            exp_p = exp_q[tag*N + o].pop_front();
            n_out++;
            if (o_data[o] !== exp_p) begin
              report_mismatch("scoreboard", 32'(exp_p), 32'(o_data[o]));
            end
          end
        end
      end
      for (int i = 0; i < N; i++) begin
        if (i_data_val[i] && o_en[i]) begin  // Accepted at the coming edge
          exp_q[i*N + expected_port(int'(i_data[i].dest_x), int'(i_data[i].dest_y))]
            .push_back(i_data[i]);
          n_in++;
        end
      end
    end
  end

  // Stimulus
  // ------------------------------
  int      dest_x [N] = '{1, 1, 3, 1, 0}; // Core, north, east, south, west of (1,2)
  int      dest_y [N] = '{2, 3, 0, 0, 3};
  packet_t sent;
  int      n_acc;
  int      n_rr_out;
  int      prev_tag;
  int      kn;
  int      ks;
  logic    acc_n;
  logic    acc_s;
  logic    drop_val;

  initial begin
    reset_n    = 1'b0;
    i_data     = '0;
    i_data_val = '0;
    i_en       = '1;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    reset_n = 1'b1;

    // Reset state
    @(negedge clk);
    n_checks++;
    if (o_data_val != '0) report_mismatch("reset_valid", 32'h0, 32'(o_data_val));
    if (o_en != '1) report_mismatch("reset_enable", 32'h1f, 32'(o_en));
    next_cycle();

    // One packet per direction with one cycle of latency
    for (int d = 0; d < N; d++) begin
      sent          = make_pkt(dest_x[d], dest_y[d], d, 16'h2000 + 16'(d));
      i_data[d]     = sent;
      i_data_val[d] = 1'b1;
      @(negedge clk);
      n_checks++;
      if (!o_en[d]) log_failure($sformatf("Idle input %0d did not accept a packet", d));
      if (o_data_val != '0) report_mismatch("latency_early", 32'h0, 32'(o_data_val));
      next_cycle();
      i_data_val[d] = 1'b0;
      @(negedge clk);
      n_checks++;
      if (o_data_val != port_set_t'(5'b1 << d)) begin
        report_mismatch("latency_routing", 32'(5'b1 << d), 32'(o_data_val));
      end
      if (o_data[d].payload !== sent.payload) begin
        report_mismatch("latency_payload", 32'(sent.payload), 32'(o_data[d].payload));
      end
      if (o_data[d].src_port !== sent.src_port) begin
        report_mismatch("latency_source", 32'(sent.src_port), 32'(o_data[d].src_port));
      end
      next_cycle();
    end

    // Back-pressure on east with five packets from core
    // ------------------------------
    i_en[PORT_EAST]        = 1'b0;
    n_acc                  = 0;
    i_data[PORT_CORE]      = make_pkt(3, 2, PORT_CORE, 16'h3000);
    i_data_val[PORT_CORE]  = 1'b1;
    repeat (8) begin
      @(negedge clk);
      n_checks++;
      if (o_data_val[PORT_EAST]) log_failure("East strobed while held off");
      if (o_en[PORT_CORE]) n_acc++;
      next_cycle();
      if (n_acc < 5) i_data[PORT_CORE] = make_pkt(3, 2, PORT_CORE, 16'h3000 + 16'(n_acc));
    end
    @(negedge clk);
    n_checks++;
    if (n_acc != 4) report_mismatch("backpressure_accepted", 32'd4, 32'(n_acc));
    if (o_en[PORT_CORE]) log_failure("Core input still enabled with a full queue");
    next_cycle();
    i_en[PORT_EAST] = 1'b1;               // Release gives four queued then the fifth
    n_acc           = 0;
    drop_val        = 1'b0;
    while (n_acc < 5) begin
      @(negedge clk);
      if (o_data_val[PORT_EAST]) begin
        n_checks++;
        if (o_data[PORT_EAST].payload !== 16'h3000 + 16'(n_acc)) begin
          report_mismatch("backpressure_order", 32'h3000 + 32'(n_acc),
                          32'(o_data[PORT_EAST].payload));
        end
        n_acc++;
      end
      drop_val = i_data_val[PORT_CORE] && o_en[PORT_CORE];
      next_cycle();
      if (drop_val) i_data_val[PORT_CORE] = 1'b0;
    end
    drain_all();

    // North and south compete for core
    // ------------------------------
    kn       = 0;
    ks       = 0;
    n_rr_out = 0;
    prev_tag = -1;
    i_data[PORT_NORTH]     = make_pkt(1, 2, PORT_NORTH, 16'h4000);
    i_data[PORT_SOUTH]     = make_pkt(1, 2, PORT_SOUTH, 16'h4100);
    i_data_val[PORT_NORTH] = 1'b1;
    i_data_val[PORT_SOUTH] = 1'b1;
    repeat (16) begin
      @(negedge clk);
      if (o_data_val[PORT_CORE]) begin
        n_checks++;
        if (prev_tag == int'(o_data[PORT_CORE].src_port)) begin
          report_mismatch("round_robin", (prev_tag == PORT_NORTH) ? PORT_SOUTH : PORT_NORTH,
                          32'(prev_tag));
        end
        prev_tag = int'(o_data[PORT_CORE].src_port);
        n_rr_out++;
      end
      acc_n = o_en[PORT_NORTH];
      acc_s = o_en[PORT_SOUTH];
      next_cycle();
      if (acc_n) begin
        kn++;
        i_data[PORT_NORTH] = make_pkt(1, 2, PORT_NORTH, 16'h4000 + 16'(kn));
      end
      if (acc_s) begin
        ks++;
        i_data[PORT_SOUTH] = make_pkt(1, 2, PORT_SOUTH, 16'h4100 + 16'(ks));
      end
    end
    n_checks++;
    if (n_rr_out < 12) log_failure("Core output starved while both inputs were busy");
    drain_all();

    // Random traffic over the whole mesh
    // ------------------------------
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      for (int p = 0; p < N; p++) begin
        rng           = xorshift(rng);
        i_data_val[p] = rng[0];
        i_data[p]     = make_pkt(int'(rng[5:4]), int'(rng[7:6]), p, rng[31:16]);
        i_en[p]       = (rng[9:8] != 2'b00); // About three in four
      end
      next_cycle();
    end
    drain_all();

    // Idle afterwards with nothing left or repeated
    repeat (4) begin
      @(negedge clk);
      n_checks++;
      if (o_data_val != '0) log_failure("Output strobed after the drain");
      if (o_en != '1) report_mismatch("idle_enable", 32'h1f, 32'(o_en));
    end

    $display("Checks %0d, errors %0d, packets in %0d, packets out %0d",
             n_checks, errors, n_in, n_out);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== hdl/crossbar_switch.sv ====
`include "noc_cfg.svh"

// One-hot crossbar, also makes output valids and queue dequeues
module crossbar_switch import noc_pkg::*, route_pkg::*; (
  input  port_set_t [`NOC_PORTS-1:0] i_sel,      // Grants, [output][input]
  input  packet_t   [`NOC_PORTS-1:0] i_data,     // Queue heads
  output packet_t   [`NOC_PORTS-1:0] o_data,     // To downstream
  output port_set_t                  o_data_val, // Strobe per output
  output port_set_t                  o_rd_en     // Dequeue per input
);

  localparam int N = `NOC_PORTS;

  port_set_t [N-1:0] sel_by_in;  // Transposed grants, [input][output]

  // Data path
  // ------------------------------
  always_comb begin
    for (int o = 0; o < N; o++) begin
      o_data[o] = '0;                     // Idle output drives zero
      for (int i = 0; i < N; i++) begin
        if (i_sel[o][i]) begin
          o_data[o] = i_data[i];
        end
      end
    end
  end

  // Valids and read enables
  // ------------------------------
  always_comb begin
    for (int o = 0; o < N; o++) begin
      o_data_val[o] = |i_sel[o];          // Granted output is valid
      for (int i = 0; i < N; i++) begin
        sel_by_in[i][o] = i_sel[o][i];
      end
    end
    for (int i = 0; i < N; i++) begin
      o_rd_en[i] = |sel_by_in[i];         // Pop when any output took it
    end
  end

  // One head cannot go to two outputs, a single read would lose a copy
  always_comb begin
    for (int i = 0; i < N; i++) begin
      a_single_dest: assert ($onehot0(sel_by_in[i]))
        else $error("crossbar input %0d granted twice", i);
    end
  end

endmodule

// ==== hdl/input_fifo.sv ====
`include "noc_cfg.svh"

// Show-ahead input queue with the head entry always on o_data
module input_fifo import noc_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,

  // Upstream side
  input  packet_t i_data,     // Packet from sender
  input  logic    i_data_val, // Sender has a packet
  output logic    o_en,       // Free entry, sender may write

  // Toward route calc and crossbar
  output packet_t o_data,     // Head packet
  output logic    o_data_val, // Head is valid
  input  logic    i_en        // Head taken at this edge
);

  localparam int DEPTH = `NOC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  packet_t          mem [DEPTH]; // Packet storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;       // Occupancy
  logic             wr;
  logic             rd;

  // Handshake
  // ------------------------------
  assign o_en       = (count != FULL_CNT);   // Low while full even with a read pending
  assign o_data_val = (count != '0);
  assign o_data     = mem[rd_ptr];           // Show-ahead head

  assign wr = i_data_val & o_en;             // Transfer on valid and enable
  assign rd = i_en & o_data_val;

  // Storage write
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers and count
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1; // Wrap at depth
      end
      if (rd) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // Both or neither
      endcase
    end
  end

  // Checks
  // ------------------------------
  a_count_in_range: assert property (
    @(posedge clk) disable iff (!reset_n) count <= FULL_CNT
  ) else $error("input_fifo occupancy above depth");

  // Crossbar must not dequeue an empty queue
  a_no_read_empty: assert property (
    @(posedge clk) disable iff (!reset_n) i_en |-> o_data_val
  ) else $error("input_fifo read while empty");

endmodule

// ==== hdl/noc_cfg.svh ====
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// Mesh geometry
// ------------------------------
`define NOC_X_NODES    4  // Routers along X
`define NOC_Y_NODES    4  // Routers along Y
`define NOC_COORD_W    2  // Bits per coordinate, covers both axes

// Packet and buffering
// ------------------------------
`define NOC_PAYLOAD_W  16 // Data bits carried per packet
`define NOC_FIFO_DEPTH 4  // Entries per input queue

// Router ports: core, north, east, south, west
`define NOC_PORTS      5

`endif

// ==== hdl/noc_pkg.sv ====
`include "noc_cfg.svh"

// Packet format shared by queues, crossbar and the links
package noc_pkg;

  // Flat packed layout, 23 bits with the default config
  // ------------------------------
  typedef struct packed {
    logic [`NOC_COORD_W-1:0]   dest_x;   // Destination column
    logic [`NOC_COORD_W-1:0]   dest_y;   // Destination row
    logic [2:0]                src_port; // Tag from the sender, carried untouched
    logic [`NOC_PAYLOAD_W-1:0] payload;  // User data
  } packet_t;

  // The router only looks at dest_x/dest_y.
  // src_port lets a checker tell which input a packet came from,
  // e.g. to confirm round-robin order on a shared output.

endpackage

// ==== hdl/noc_router.sv ====
`include "noc_cfg.svh"

// Input-buffered 5-port mesh router
// Queue -> route calc -> switch control -> crossbar
module noc_router import noc_pkg::*, route_pkg::*; #(
  parameter int X_LOC = 0, // Column in the mesh
  parameter int Y_LOC = 0  // Row in the mesh
) (
  input  logic                       clk,
  input  logic                       reset_n,

  // Upstream links [core, north, east, south, west]
  // ------------------------------
  input  packet_t   [`NOC_PORTS-1:0] i_data,
  input  port_set_t                  i_data_val,
  output port_set_t                  o_en,

  // Downstream links
  // ------------------------------
  output packet_t   [`NOC_PORTS-1:0] o_data,
  output port_set_t                  o_data_val,
  input  port_set_t                  i_en
);

  localparam int N = `NOC_PORTS;

  packet_t   [N-1:0] head_data;    // Queue heads
  port_set_t         head_val;     // Queue not empty
  port_set_t         rd_en;        // Dequeue from crossbar
  port_set_t [N-1:0] output_req;   // [input][output]
  port_set_t [N-1:0] output_grant; // [output][input]

  // Input queues and route calculators, one pair per port
  // ------------------------------
  for (genvar i = 0; i < N; i++) begin : g_in
    input_fifo u_fifo (
      .clk,
      .reset_n,
      .i_data     (i_data[i]),
      .i_data_val (i_data_val[i]),
      .i_en       (rd_en[i]),       // From crossbar
      .o_data     (head_data[i]),
      .o_data_val (head_val[i]),
      .o_en       (o_en[i])         // Back to upstream
    );

    route_calc #(.X_LOC(X_LOC), .Y_LOC(Y_LOC)) u_route (
      .i_dest_x     (head_data[i].dest_x),
      .i_dest_y     (head_data[i].dest_y),
      .i_val        (head_val[i]),
      .o_output_req (output_req[i])
    );
  end

  // Arbitration, gated by downstream enables
  switch_control u_switch_control (
    .clk,
    .reset_n,
    .i_en           (i_en),
    .i_output_req   (output_req),
    .o_output_grant (output_grant)
  );

  // Data crossbar
  crossbar_switch u_crossbar (
    .i_sel      (output_grant),
    .i_data     (head_data),
    .o_data     (o_data),
    .o_data_val (o_data_val),     // Only when i_en is high
    .o_rd_en    (rd_en)
  );

endmodule

// ==== hdl/route_calc.sv ====
`include "noc_cfg.svh"

// Dimension-ordered XY routing, X first then Y
module route_calc import route_pkg::*; #(
  parameter int X_LOC = 0, // Column of this router
  parameter int Y_LOC = 0  // Row of this router
) (
  input  logic [`NOC_COORD_W-1:0] i_dest_x, // Head packet destination
  input  logic [`NOC_COORD_W-1:0] i_dest_y,
  input  logic                    i_val,    // Head present
  output port_set_t               o_output_req
);

  localparam logic [`NOC_COORD_W-1:0] X_POS = `NOC_COORD_W'(X_LOC);
  localparam logic [`NOC_COORD_W-1:0] Y_POS = `NOC_COORD_W'(Y_LOC);

  // Router must sit inside the mesh
  if (X_LOC >= `NOC_X_NODES || Y_LOC >= `NOC_Y_NODES) begin : g_bad_loc
    $error("route_calc location outside the mesh");
  end

  always_comb begin
    o_output_req = '0;
    if (i_val) begin
      if (i_dest_x > X_POS) begin
        o_output_req[PORT_EAST] = 1'b1;         // Resolve X first
      end else if (i_dest_x < X_POS) begin
        o_output_req[PORT_WEST] = 1'b1;
      end else if (i_dest_y > Y_POS) begin
        o_output_req[PORT_NORTH] = 1'b1;        // Same column, go along Y
      end else if (i_dest_y < Y_POS) begin
        o_output_req[PORT_SOUTH] = 1'b1;
      end else begin
        o_output_req[PORT_CORE] = 1'b1;         // Arrived
      end
    end
  end

  // Switch control relies on a single request per head
  always_comb begin
    a_req_onehot: assert (!i_val || $onehot(o_output_req))
      else $error("route_calc request not one-hot");
  end

endmodule

// ==== hdl/route_pkg.sv ====
`include "noc_cfg.svh"

// Port naming and request/grant vectors
package route_pkg;

  // Bit positions inside a port set
  // ------------------------------
  localparam int PORT_CORE  = 0; // Local tile
  localparam int PORT_NORTH = 1; // Toward larger y
  localparam int PORT_EAST  = 2; // Toward larger x
  localparam int PORT_SOUTH = 3; // Toward smaller y
  localparam int PORT_WEST  = 4; // Toward smaller x

  // One bit per router port, one-hot for a route request,
  // zero when nothing is requested or granted
  typedef logic [`NOC_PORTS-1:0] port_set_t;

endpackage

// ==== hdl/switch_control.sv ====
`include "noc_cfg.svh"

// Per-output round-robin arbitration
// Requests arrive per input, grants leave per output
module switch_control import route_pkg::*; (
  input  logic                        clk,
  input  logic                        reset_n,
  input  port_set_t                   i_en,           // Downstream enables, one per output
  input  port_set_t [`NOC_PORTS-1:0]  i_output_req,   // Indexed [input][output]
  output port_set_t [`NOC_PORTS-1:0]  o_output_grant  // Indexed [output][input]
);

  localparam int N    = `NOC_PORTS;
  localparam int PW   = $clog2(N);
  localparam logic [PW-1:0] LAST_IN = PW'(N - 1);

  port_set_t [N-1:0] req_by_out;  // Transposed requests, [output][input]
  logic [PW-1:0]     ptr [N];     // Highest-priority input per output
  logic [PW-1:0]     grant_idx [N];

  // Transpose so each output sees its requesters
  // ------------------------------
  always_comb begin
    for (int o = 0; o < N; o++) begin
      for (int i = 0; i < N; i++) begin
        req_by_out[o][i] = i_output_req[i][o];
      end
    end
  end

  // Arbitration
  // ------------------------------
  always_comb begin
    int  idx;
    logic found;
    idx   = 0;
    found = 1'b0;
    for (int o = 0; o < N; o++) begin
      o_output_grant[o] = '0;
      grant_idx[o]      = '0;
      found             = 1'b0;
      for (int k = 0; k < N; k++) begin
        idx = int'(ptr[o]) + k;               // Search from the pointer
        if (idx >= N) begin
          idx = idx - N;                      // Wrap around
        end
        if (!found && i_en[o] && req_by_out[o][idx]) begin
          o_output_grant[o][idx] = 1'b1;      // First requester wins
          grant_idx[o]           = PW'(idx);
          found                  = 1'b1;
        end
      end
    end
  end

  // Pointer moves one past the winner
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int o = 0; o < N; o++) begin
        ptr[o] <= '0;                         // Input 0 first after reset
      end
    end else begin
      for (int o = 0; o < N; o++) begin
        if (o_output_grant[o] != '0) begin
          ptr[o] <= (grant_idx[o] == LAST_IN) ? '0 : grant_idx[o] + 1'b1;
        end
      end
    end
  end

  // Checks
  // ------------------------------
  for (genvar o = 0; o < N; o++) begin : g_chk
    a_grant_onehot0: assert property (
      @(posedge clk) disable iff (!reset_n) $onehot0(o_output_grant[o])
    ) else $error("switch_control grant %0d not one-hot", o);

    // A grant needs a matching request and a free downstream
    a_grant_legal: assert property (
      @(posedge clk) disable iff (!reset_n)
      (o_output_grant[o] != '0) |->
        (i_en[o] && (o_output_grant[o] & ~req_by_out[o]) == '0)
    ) else $error("switch_control grant %0d without request or enable", o);
  end

endmodule
